//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= tb_alu_exec
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module alu_exec_top rtl/simt_pkg.sv \
		rtl/alu_unit.sv rtl/alu_csr.sv rtl/alu_exec_top.sv
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "NO ERRORS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- flist.f
rtl/simt_pkg.sv
rtl/alu_unit.sv
rtl/alu_csr.sv
rtl/alu_exec_top.sv
tests/alu_checker.sv
tests/tb_alu_exec.sv

//--- rtl/alu_csr.sv
`timescale 1ns/1ps

module alu_csr (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  logic [1:0]           wb_adr,
    input  simt_pkg::word_t      wb_dat_w,
    output simt_pkg::word_t      wb_dat_r,
    output logic                 wb_ack,
    output simt_pkg::lane_mask_t lane_en,
    input  logic                 commit_fire,
    input  logic                 taken_fire
);

    logic            access;
    logic            wr_en;
    logic            clear;
    simt_pkg::word_t commit_cnt;
    simt_pkg::word_t taken_cnt;
    simt_pkg::word_t rd_data;

    // the ack cycle is not decoded again, so a held strobe gives one access
    assign access = wb_cyc & wb_stb & ~wb_ack;
    assign wr_en  = access & wb_we;
    assign clear  = wr_en & (wb_adr == simt_pkg::CSR_CLEAR);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= access;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lane_en <= '1;
        end else if (wr_en && wb_adr == simt_pkg::CSR_MASK) begin
            lane_en <= wb_dat_w[simt_pkg::NUM_THREADS-1:0];
        end
    end

    // clear wins over an increment in the same cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            commit_cnt <= '0;
            taken_cnt  <= '0;
        end else if (clear) begin
            commit_cnt <= '0;
            taken_cnt  <= '0;
        end else begin
            if (commit_fire) begin
                commit_cnt <= commit_cnt + 1'b1;
            end
            if (taken_fire) begin
                taken_cnt <= taken_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        case (wb_adr)
            simt_pkg::CSR_MASK:    rd_data = simt_pkg::word_t'(lane_en);
            simt_pkg::CSR_COMMITS: rd_data = commit_cnt;
            simt_pkg::CSR_TAKEN:   rd_data = taken_cnt;
            default:               rd_data = '0;
        endcase
    end

    // sampled on the access edge, so a read sees counts before that edge's increment
    always_ff @(posedge clk) begin
        if (access) begin
            wb_dat_r <= rd_data;
        end
    end

    a_ack_in_cycle: assert property (
        @(posedge clk) disable iff (!arst_n) wb_ack |-> (wb_cyc && wb_stb)
    ) else $error("wb_ack outside an active bus cycle");

endmodule

//--- rtl/alu_exec_top.sv
`timescale 1ns/1ps

module alu_exec_top (
    input  logic                  clk,
    input  logic                  arst_n,
    input  simt_pkg::alu_req_t    alu_req,
    output logic                  req_ready,
    output simt_pkg::commit_t     commit,
    input  logic                  commit_ready,
    output simt_pkg::branch_ctl_t branch_ctl,
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  logic [1:0]            wb_adr,
    input  simt_pkg::word_t       wb_dat_w,
    output simt_pkg::word_t       wb_dat_r,
    output logic                  wb_ack
);

    simt_pkg::lane_mask_t lane_en;
    logic                 commit_fire;
    logic                 taken_fire;

    alu_unit u_alu (
        .clk          (clk),
        .arst_n       (arst_n),
        .alu_req      (alu_req),
        .req_ready    (req_ready),
        .lane_en      (lane_en),
        .commit       (commit),
        .commit_ready (commit_ready),
        .branch_ctl   (branch_ctl),
        .commit_fire  (commit_fire),
        .taken_fire   (taken_fire)
    );

    alu_csr u_csr (
        .clk         (clk),
        .arst_n      (arst_n),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .lane_en     (lane_en),
        .commit_fire (commit_fire),
        .taken_fire  (taken_fire)
    );

endmodule

//--- rtl/alu_unit.sv
`timescale 1ns/1ps

module alu_unit (
    input  logic                    clk,
    input  logic                    arst_n,
    input  simt_pkg::alu_req_t      alu_req,
    output logic                    req_ready,
    input  simt_pkg::lane_mask_t    lane_en,
    output simt_pkg::commit_t       commit,
    input  logic                    commit_ready,
    output simt_pkg::branch_ctl_t   branch_ctl,
    output logic                    commit_fire,
    output logic                    taken_fire
);

    simt_pkg::lane_mask_t                        active;
    logic                                        sub_signed;
    logic [simt_pkg::NUM_THREADS-1:0][32:0]      sub_res;
    simt_pkg::word_t [simt_pkg::NUM_THREADS-1:0] lane_res;
    simt_pkg::lane_idx_t                         br_lane;
    logic [32:0]                                 br_sub;
    logic                                        br_sign;
    logic                                        br_nzero;
    logic                                        is_branch;
    logic                                        br_taken;
    simt_pkg::word_t                             br_base;
    simt_pkg::word_t                             br_dest;
    logic                                        stall;
    logic                                        req_fire;

    simt_pkg::lane_mask_t                        valid_q;
    simt_pkg::warp_id_t                          warp_q;
    simt_pkg::word_t                             pc_q;
    simt_pkg::reg_id_t                           rd_q;
    logic                                        wb_q;
    simt_pkg::word_t [simt_pkg::NUM_THREADS-1:0] data_q;
    logic                                        br_valid_q;
    logic                                        br_taken_q;
    simt_pkg::word_t                             br_dest_q;

    assign active = alu_req.valid & lane_en;

    // unsigned compares zero-extend, everything else sign-extends into bit 32
    assign sub_signed = !(alu_req.op inside {simt_pkg::SLTU, simt_pkg::BLTU, simt_pkg::BGEU});

    for (genvar i = 0; i < simt_pkg::NUM_THREADS; i++) begin : g_lane
        logic [32:0]     sub_a;
        logic [32:0]     sub_b;
        logic [32:0]     shr_a;
        logic [32:0]     shr_res;
        simt_pkg::word_t res;

        assign sub_a      = {sub_signed & alu_req.rs1[i][31], alu_req.rs1[i]};
        assign sub_b      = {sub_signed & alu_req.rs2[i][31], alu_req.rs2[i]};
        assign sub_res[i] = sub_a - sub_b;

        // bit 32 holds the sign only for SRA so SRL shifts in zeros
        assign shr_a   = {(alu_req.op == simt_pkg::SRA) & alu_req.rs1[i][31], alu_req.rs1[i]};
        assign shr_res = $signed(shr_a) >>> alu_req.rs2[i][4:0];

        always_comb begin
            case (alu_req.op)
                simt_pkg::SUB:  res = sub_res[i][31:0];
                simt_pkg::SLL:  res = alu_req.rs1[i] << alu_req.rs2[i][4:0];
                simt_pkg::SLT,
                simt_pkg::SLTU: res = simt_pkg::word_t'(sub_res[i][32]);
                simt_pkg::XOR:  res = alu_req.rs1[i] ^ alu_req.rs2[i];
                simt_pkg::SRL,
                simt_pkg::SRA:  res = shr_res[31:0];
                simt_pkg::OR:   res = alu_req.rs1[i] | alu_req.rs2[i];
                simt_pkg::AND:  res = alu_req.rs1[i] & alu_req.rs2[i];
                simt_pkg::JAL,
                simt_pkg::JALR: res = alu_req.next_pc;
                default:        res = alu_req.rs1[i] + alu_req.rs2[i];
            endcase
        end

        assign lane_res[i] = res;
    end

    // the lowest active lane decides the branch for the whole warp
    always_comb begin
        br_lane = '0;
        for (int i = simt_pkg::NUM_THREADS - 1; i >= 0; i--) begin
            if (active[i]) begin
                br_lane = simt_pkg::lane_idx_t'(i);
            end
        end
    end

    assign br_sub   = sub_res[br_lane];
    assign br_sign  = br_sub[32];
    assign br_nzero = |br_sub[31:0];

    assign is_branch = alu_req.op inside {simt_pkg::JAL, simt_pkg::JALR,
                                          simt_pkg::BEQ, simt_pkg::BNE,
                                          simt_pkg::BLT, simt_pkg::BGE,
                                          simt_pkg::BLTU, simt_pkg::BGEU};

    always_comb begin
        case (alu_req.op)
            simt_pkg::BEQ:  br_taken = ~br_nzero;
            simt_pkg::BNE:  br_taken = br_nzero;
            simt_pkg::BLT,
            simt_pkg::BLTU: br_taken = br_sign;
            simt_pkg::BGE,
            simt_pkg::BGEU: br_taken = ~br_sign;
            default:        br_taken = 1'b1;
        endcase
    end

    assign br_base = (alu_req.op == simt_pkg::JALR) ? alu_req.rs1[br_lane] : alu_req.curr_pc;
    assign br_dest = br_base + alu_req.offset;

    assign stall     = (|valid_q) & ~commit_ready;
    assign req_ready = ~stall;
    assign req_fire  = (|active) & req_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q    <= '0;
            br_valid_q <= 1'b0;
        end else if (!stall) begin
            valid_q    <= active;
            br_valid_q <= is_branch & (|active);
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            warp_q     <= alu_req.warp;
            pc_q       <= alu_req.curr_pc;
            rd_q       <= alu_req.rd;
            wb_q       <= alu_req.wb;
            data_q     <= lane_res;
            br_taken_q <= br_taken;
            br_dest_q  <= br_dest;
        end
    end

    always_comb begin
        commit.valid     = valid_q;
        commit.warp      = warp_q;
        commit.curr_pc   = pc_q;
        commit.rd        = rd_q;
        commit.wb        = wb_q;
        commit.data      = data_q;
        branch_ctl.valid = br_valid_q;
        branch_ctl.warp  = warp_q;
        branch_ctl.taken = br_taken_q;
        branch_ctl.dest  = br_dest_q;
    end

    assign commit_fire = (|valid_q) & commit_ready;
    assign taken_fire  = commit_fire & br_valid_q & br_taken_q;

    a_hold_on_stall: assert property (
        @(posedge clk) disable iff (!arst_n) stall |=> $stable(commit)
    ) else $error("commit record changed while stalled");

    a_branch_has_commit: assert property (
        @(posedge clk) disable iff (!arst_n) branch_ctl.valid |-> (|commit.valid)
    ) else $error("branch record without a commit record");

endmodule

//--- rtl/simt_pkg.sv
package simt_pkg;

    localparam int NUM_THREADS = 4;
    localparam int NUM_WARPS   = 4;

    typedef logic [31:0]                    word_t;
    typedef logic [NUM_THREADS-1:0]         lane_mask_t;
    typedef logic [$clog2(NUM_WARPS)-1:0]   warp_id_t;
    typedef logic [4:0]                     reg_id_t;
    typedef logic [$clog2(NUM_THREADS)-1:0] lane_idx_t;

    // the last six are conditional branches, resolved from the subtract result
    typedef enum logic [4:0] {
        ADD, SUB, SLL, SLT, SLTU,
        XOR, SRL, SRA, OR, AND,
        LUI, JAL, JALR,
        BEQ, BNE, BLT, BGE, BLTU, BGEU
    } alu_op_e;

    typedef struct packed {
        lane_mask_t                valid;
        warp_id_t                  warp;
        alu_op_e                   op;
        reg_id_t                   rd;
        logic                      wb;
        word_t                     curr_pc;
        word_t                     next_pc;
        word_t                     offset;
        word_t [NUM_THREADS-1:0]   rs1;
        word_t [NUM_THREADS-1:0]   rs2;
    } alu_req_t;

    typedef struct packed {
        lane_mask_t                valid;
        warp_id_t                  warp;
        word_t                     curr_pc;
        reg_id_t                   rd;
        logic                      wb;
        word_t [NUM_THREADS-1:0]   data;
    } commit_t;

    typedef struct packed {
        logic                      valid;
        warp_id_t                  warp;
        logic                      taken;
        word_t                     dest;
    } branch_ctl_t;

    // word addresses of the register block
    localparam logic [1:0] CSR_MASK    = 2'd0;
    localparam logic [1:0] CSR_COMMITS = 2'd1;
    localparam logic [1:0] CSR_TAKEN   = 2'd2;
    localparam logic [1:0] CSR_CLEAR   = 2'd3;

endpackage

//--- tests/alu_checker.sv
`timescale 1ns/1ps

module alu_checker (
    input logic                  clk,
    input logic                  arst_n,
    input simt_pkg::commit_t     commit,
    input logic                  commit_ready,
    input simt_pkg::branch_ctl_t branch_ctl,
    input logic                  req_ready
);

    simt_pkg::commit_t     exp_commit_q[$];
    simt_pkg::branch_ctl_t exp_branch_q[$];
    int                    err_count = 0;
    int                    delivered = 0;

    function automatic void push_expected(simt_pkg::commit_t c, simt_pkg::branch_ctl_t b);
        exp_commit_q.push_back(c);
        exp_branch_q.push_back(b);
    endfunction

    function automatic int pending();
        return exp_commit_q.size();
    endfunction

    function automatic void compare(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%08h expected 0x%08h", name, got, exp);
            err_count++;
        end
    endfunction

    // inputs change on the falling edge, so the rising edge sees settled values
    always @(posedge clk) begin : watch
        simt_pkg::commit_t     ec;
        simt_pkg::branch_ctl_t eb;
        if (arst_n) begin
            compare("req_ready", 32'(req_ready), 32'(!((|commit.valid) && !commit_ready)));
            if ((|commit.valid) && commit_ready) begin
                delivered++;
                if (exp_commit_q.size() == 0) begin
                    $display("a commit record was delivered while none was expected");
                    err_count++;
                end else begin
                    ec = exp_commit_q.pop_front();
                    eb = exp_branch_q.pop_front();
                    compare("commit.valid", 32'(commit.valid), 32'(ec.valid));
                    compare("commit.warp", 32'(commit.warp), 32'(ec.warp));
                    compare("commit.curr_pc", commit.curr_pc, ec.curr_pc);
                    compare("commit.rd", 32'(commit.rd), 32'(ec.rd));
                    compare("commit.wb", 32'(commit.wb), 32'(ec.wb));
                    for (int i = 0; i < simt_pkg::NUM_THREADS; i++) begin
                        compare($sformatf("commit.data[%0d]", i), commit.data[i], ec.data[i]);
                    end
                    compare("branch_ctl.valid", 32'(branch_ctl.valid), 32'(eb.valid));
                    if (eb.valid) begin
                        compare("branch_ctl.warp", 32'(branch_ctl.warp), 32'(eb.warp));
                        compare("branch_ctl.taken", 32'(branch_ctl.taken), 32'(eb.taken));
                        compare("branch_ctl.dest", branch_ctl.dest, eb.dest);
                    end
                end
            end
        end
    end

endmodule

//--- tests/tb_alu_exec.sv
`timescale 1ns/1ps

module tb_alu_exec;

    localparam int CLK_PERIOD = 8;
    localparam int TIMEOUT    = 200;
    localparam int NUM_ROWS   = 21;
    localparam int NUM_ALU    = 19;

    typedef simt_pkg::word_t [simt_pkg::NUM_THREADS-1:0] lane_words_t;

    typedef struct packed {
        simt_pkg::alu_op_e    op;
        simt_pkg::lane_mask_t valid;
        simt_pkg::lane_mask_t exp_valid;
        lane_words_t          rs1;
        lane_words_t          rs2;
        simt_pkg::word_t      offset;
        lane_words_t          exp_data;
        logic                 bv;
        logic                 bt;
        simt_pkg::word_t      bd;
    } row_t;

    logic                  clk;
    logic                  arst_n;
    simt_pkg::alu_req_t    alu_req;
    logic                  req_ready;
    simt_pkg::commit_t     commit;
    logic                  commit_ready;
    simt_pkg::branch_ctl_t branch_ctl;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    logic [1:0]            wb_adr;
    simt_pkg::word_t       wb_dat_w;
    simt_pkg::word_t       wb_dat_r;
    logic                  wb_ack;

    row_t            rows [NUM_ROWS];
    int              n_rows;
    int              seed;
    bit              rand_ready;
    int              tb_errors;
    int              exp_commits;
    int              exp_taken;
    simt_pkg::word_t rd_val;

    alu_exec_top DUT (.*);

    alu_checker chk (
        .clk          (clk),
        .arst_n       (arst_n),
        .commit       (commit),
        .commit_ready (commit_ready),
        .branch_ctl   (branch_ctl),
        .req_ready    (req_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // lane 0 is the first argument
    function automatic lane_words_t lw(simt_pkg::word_t a0, simt_pkg::word_t a1,
                                       simt_pkg::word_t a2, simt_pkg::word_t a3);
        return {a3, a2, a1, a0};
    endfunction

    task automatic add_row(simt_pkg::alu_op_e op, simt_pkg::lane_mask_t valid,
                           simt_pkg::lane_mask_t exp_valid, lane_words_t rs1, lane_words_t rs2,
                           simt_pkg::word_t offset, lane_words_t exp_data,
                           logic bv, logic bt, simt_pkg::word_t bd);
        rows[n_rows] = '{op, valid, exp_valid, rs1, rs2, offset, exp_data, bv, bt, bd};
        n_rows++;
    endtask

    // every row uses curr_pc 0x100 and next_pc 0x104
    task automatic build_table();
        n_rows = 0;
        add_row(simt_pkg::ADD, 4'hf, 4'hf, lw(1, 2, 32'hffffffff, 32'h7fffffff), lw(1, 3, 1, 1),
                32'h20, lw(2, 5, 0, 32'h80000000), 0, 0, 0);
        add_row(simt_pkg::SUB, 4'hf, 4'hf, lw(5, 0, 32'h80000000, 16), lw(3, 1, 1, 16),
                32'h20, lw(2, 32'hffffffff, 32'h7fffffff, 0), 0, 0, 0);
        add_row(simt_pkg::SLL, 4'hf, 4'hf, lw(1, 1, 3, 32'hffffffff), lw(0, 4, 31, 32'h24),
                32'h20, lw(1, 32'h10, 32'h80000000, 32'hfffffff0), 0, 0, 0);
        add_row(simt_pkg::SLT, 4'hf, 4'hf, lw(32'hffffffff, 1, 5, 32'h80000000),
                lw(1, 32'hffffffff, 5, 32'h7fffffff), 32'h20, lw(1, 0, 0, 1), 0, 0, 0);
        add_row(simt_pkg::SLTU, 4'hf, 4'hf, lw(32'hffffffff, 1, 5, 32'h80000000),
                lw(1, 32'hffffffff, 5, 32'h7fffffff), 32'h20, lw(0, 1, 0, 0), 0, 0, 0);
        add_row(simt_pkg::XOR, 4'hf, 4'hf, lw(32'hf0f0f0f0, 0, 32'hffffffff, 32'h12345678),
                lw(32'h0f0f0f0f, 0, 32'hffffffff, 0), 32'h20,
                lw(32'hffffffff, 0, 0, 32'h12345678), 0, 0, 0);
        add_row(simt_pkg::SRL, 4'hf, 4'hf, lw(32'h80000000, 32'hffffffff, 32'h100, 32'hf0000000),
                lw(4, 31, 8, 0), 32'h20, lw(32'h08000000, 1, 1, 32'hf0000000), 0, 0, 0);
        add_row(simt_pkg::SRA, 4'hf, 4'hf, lw(32'h80000000, 32'hffffffff, 32'h100, 32'hf0000000),
                lw(4, 31, 8, 0), 32'h20,
                lw(32'hf8000000, 32'hffffffff, 1, 32'hf0000000), 0, 0, 0);
        add_row(simt_pkg::OR, 4'hf, 4'hf, lw(32'hf0, 0, 1, 0), lw(32'h0f, 0, 2, 32'h80000000),
                32'h20, lw(32'hff, 0, 3, 32'h80000000), 0, 0, 0);
        add_row(simt_pkg::AND, 4'hf, 4'hf, lw(32'hff, 32'hffffffff, 0, 32'hf0f0),
                lw(32'h0f, 32'h12345678, 32'hffffffff, 32'hff00), 32'h20,
                lw(32'h0f, 32'h12345678, 0, 32'hf000), 0, 0, 0);
        add_row(simt_pkg::LUI, 4'hf, 4'hf, lw(0, 0, 0, 1),
                lw(32'h12345000, 32'habcde000, 0, 32'hfffff000), 32'h20,
                lw(32'h12345000, 32'habcde000, 0, 32'hfffff001), 0, 0, 0);
        add_row(simt_pkg::JAL, 4'hf, 4'hf, lw(7, 7, 7, 7), lw(9, 9, 9, 9),
                32'h20, lw(32'h104, 32'h104, 32'h104, 32'h104), 1, 1, 32'h120);
        // lane 0 is off, so lane 1's rs1 forms the target
        add_row(simt_pkg::JALR, 4'he, 4'he, lw(32'h1000, 32'h2000, 32'h3000, 32'h4000),
                lw(0, 0, 0, 0), 32'h8, lw(32'h104, 32'h104, 32'h104, 32'h104), 1, 1, 32'h2008);
        add_row(simt_pkg::BEQ, 4'hf, 4'hf, lw(5, 1, 0, 0), lw(5, 2, 0, 0),
                32'h20, lw(10, 3, 0, 0), 1, 1, 32'h120);
        add_row(simt_pkg::BNE, 4'hf, 4'hf, lw(5, 1, 0, 0), lw(5, 2, 0, 0),
                32'h20, lw(10, 3, 0, 0), 1, 0, 32'h120);
        add_row(simt_pkg::BLT, 4'hf, 4'hf, lw(32'hffffffff, 0, 0, 0), lw(1, 0, 0, 0),
                32'h20, lw(0, 0, 0, 0), 1, 1, 32'h120);
        add_row(simt_pkg::BLTU, 4'hf, 4'hf, lw(32'hffffffff, 0, 0, 0), lw(1, 0, 0, 0),
                32'h20, lw(0, 0, 0, 0), 1, 0, 32'h120);
        add_row(simt_pkg::BGE, 4'hf, 4'hf, lw(32'hffffffff, 0, 0, 0), lw(1, 0, 0, 0),
                32'h20, lw(0, 0, 0, 0), 1, 0, 32'h120);
        add_row(simt_pkg::BGEU, 4'hf, 4'hf, lw(32'hffffffff, 0, 0, 0), lw(1, 0, 0, 0),
                32'h20, lw(0, 0, 0, 0), 1, 1, 32'h120);
        // run with the lane mask at 0xc, lane 2 now decides and its operands differ
        add_row(simt_pkg::BEQ, 4'hf, 4'hc, lw(5, 5, 7, 7), lw(5, 5, 1, 7),
                32'h20, lw(10, 10, 8, 14), 1, 0, 32'h120);
        add_row(simt_pkg::ADD, 4'h3, 4'h0, lw(1, 1, 1, 1), lw(1, 1, 1, 1),
                32'h20, lw(2, 2, 2, 2), 0, 0, 0);
    endtask

    task automatic send_row(int idx);
        row_t                  r;
        simt_pkg::commit_t     ec;
        simt_pkg::branch_ctl_t eb;
        int                    cnt;
        bit                    accepted;
        r        = rows[idx];
        cnt      = 0;
        accepted = 0;
        while (!accepted && cnt < TIMEOUT) begin
            @(negedge clk);
            if (rand_ready) begin
                commit_ready = ($random(seed) & 1) != 0;
            end
            alu_req.valid   = r.valid;
            alu_req.warp    = idx[1:0];
            alu_req.op      = r.op;
            alu_req.rd      = idx[4:0];
            alu_req.wb      = 1'b1;
            alu_req.curr_pc = 32'h100;
            alu_req.next_pc = 32'h104;
            alu_req.offset  = r.offset;
            alu_req.rs1     = r.rs1;
            alu_req.rs2     = r.rs2;
            #2;
            if (req_ready) begin
                accepted = 1;
                if (r.exp_valid != '0) begin
                    ec = '{r.exp_valid, idx[1:0], 32'h100, idx[4:0], 1'b1, r.exp_data};
                    eb = '{r.bv, idx[1:0], r.bt, r.bd};
                    chk.push_expected(ec, eb);
                    exp_commits++;
                    if (r.bv && r.bt) begin
                        exp_taken++;
                    end
                end
            end
            cnt++;
        end
        if (!accepted) begin
            $display("request from row %0d was never accepted", idx);
            tb_errors++;
        end
    endtask

    task automatic drain();
        int cnt;
        cnt = 0;
        @(negedge clk);
        alu_req.valid = '0;
        commit_ready  = 1'b1;
        while (chk.pending() > 0 && cnt < TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (chk.pending() > 0) begin
            $display("%0d commit records were never delivered", chk.pending());
            tb_errors++;
        end
    endtask

    task automatic wb_access(logic we, logic [1:0] adr, simt_pkg::word_t wdata,
                             output simt_pkg::word_t rdata);
        int cnt;
        cnt = 0;
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        @(negedge clk);
        while (!wb_ack && cnt < TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (!wb_ack) begin
            $display("no Wishbone ack for address %0d", adr);
            tb_errors++;
        end
        rdata = wb_dat_r;
        // the strobe stays up through the rising edge that samples ack
        @(negedge clk);
        if (wb_ack) begin
            $display("Wishbone ack stayed high for a second cycle");
            tb_errors++;
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic check_read(logic [1:0] adr, simt_pkg::word_t exp, string name);
        wb_access(1'b0, adr, '0, rd_val);
        if (rd_val !== exp) begin
            $display("[FAIL] %s: got 0x%08h expected 0x%08h", name, rd_val, exp);
            tb_errors++;
        end
    endtask

    initial begin
        seed         = 1511;
        rand_ready   = 0;
        tb_errors    = 0;
        exp_commits  = 0;
        exp_taken    = 0;
        arst_n       = 1'b0;
        alu_req      = '0;
        commit_ready = 1'b1;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = '0;
        wb_dat_w     = '0;
        build_table();
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        for (int i = 0; i < NUM_ALU; i++) begin
            send_row(i);
        end
        drain();

        // same table again with the consumer stalling at random
        rand_ready = 1;
        for (int i = 0; i < NUM_ALU; i++) begin
            send_row(i);
        end
        rand_ready = 0;
        drain();

        wb_access(1'b1, simt_pkg::CSR_MASK, 32'hc, rd_val);
        check_read(simt_pkg::CSR_MASK, 32'hc, "wb_dat_r (CSR_MASK)");
        send_row(NUM_ALU);
        send_row(NUM_ALU + 1);
        drain();
        wb_access(1'b1, simt_pkg::CSR_MASK, 32'hf, rd_val);

        check_read(simt_pkg::CSR_COMMITS, exp_commits, "wb_dat_r (CSR_COMMITS)");
        check_read(simt_pkg::CSR_TAKEN, exp_taken, "wb_dat_r (CSR_TAKEN)");
        wb_access(1'b1, simt_pkg::CSR_CLEAR, 32'h1, rd_val);
        check_read(simt_pkg::CSR_COMMITS, 0, "wb_dat_r (CSR_COMMITS)");
        check_read(simt_pkg::CSR_TAKEN, 0, "wb_dat_r (CSR_TAKEN)");
        check_read(simt_pkg::CSR_CLEAR, 0, "wb_dat_r (CSR_CLEAR)");

        $display("errors: %0d from the checker, %0d from the testbench, %0d records delivered",
                 chk.err_count, tb_errors, chk.delivered);
        if (chk.err_count == 0 && tb_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
